// ==== logic/pll_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_cfg_regs (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // host write port, single-cycle strobe
    input  wire logic                       host_wr,
    input  wire logic [`PLL_ADDR_W-1:0]     host_addr,
    input  wire logic [`PLL_DATA_W-1:0]     host_wdata,
    // decoded control towards the sequencer
    output      logic                       pll_enable,
    output      logic                       apply,
    output      pll_map_pkg::ratio_t        new_ratio,
    output      pll_map_pkg::ratio_sel_e    new_sel,
    output      logic [`PLL_VCODIV_W-1:0]   new_vcodiv
);

    import pll_map_pkg::*;

    logic ctrl_wr;
    logic ratio_wr;

    // address decode
    // anything other than CTRL or RATIO falls through untouched
    assign ctrl_wr  = host_wr && (host_addr == `PLL_ADDR_CTRL);
    assign ratio_wr = host_wr && (host_addr == `PLL_ADDR_RATIO);

    // enable level and apply pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // pll comes up enabled
            pll_enable <= 1'b1;
            apply      <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                // bit 0 only, upper bits reserved
                pll_enable <= host_wdata[0];
            end
            // high for exactly the cycle after a RATIO write
            // back-to-back writes keep it high, one update per cycle
            apply <= ratio_wr;
        end
    end

    // held ratio fields
    // loaded on the same edge that raises apply
    always_ff @(posedge clk) begin
        if (ratio_wr) begin
            // bits 9..0
            new_ratio  <= host_wdata[`PLL_RATIO_W-1:0];
            // bits 11..10
            new_sel    <= ratio_sel_e'(host_wdata[`PLL_SEL_LSB +: 2]);
            // bits 13..12
            new_vcodiv <= host_wdata[`PLL_VCODIV_LSB +: `PLL_VCODIV_W];
        end
    end

    // bits 15..14 of RATIO are spare and dropped

endmodule : pll_cfg_regs

`default_nettype wire

// ==== logic/pll_lock_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_lock_timer #(
    // settle time of the pll in clk cycles, at least 1
    parameter int unsigned LOCK_CYCLES = `PLL_LOCK_CYCLES
) (
    input  wire logic clk,
    input  wire logic rst_n,
    // high while the sequencer sits in SET
    input  wire logic lock_count_en,
    // settle time elapsed
    output      logic lock_done
);

    // enough bits to hold LOCK_CYCLES itself
    localparam int unsigned CNT_W = $clog2(LOCK_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(LOCK_CYCLES);

    logic [CNT_W-1:0] count;

    // saturating up-counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!lock_count_en) begin
            // any exit from SET clears it,
            // so every new entry waits the full time
            count <= '0;
        end else if (count != CNT_MAX) begin
            count <= count + 1'b1;
        end
    end

    // stays high until the enable drops
    assign lock_done = (count == CNT_MAX);

    // with the enable high from edge n, lock_done shows after edge n+LOCK_CYCLES

endmodule : pll_lock_timer

`default_nettype wire

// ==== logic/pll_map_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_map_core (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // from the register block
    input  wire logic                       pll_enable,
    input  wire logic                       apply,
    input  wire pll_map_pkg::ratio_t        new_ratio,
    input  wire pll_map_pkg::ratio_sel_e    new_sel,
    input  wire logic [`PLL_VCODIV_W-1:0]   new_vcodiv,
    // lock timer handshake
    input  wire logic                       lock_done,
    output      logic                       lock_count_en,
    // pll macro controls
    output      logic                       pllen,
    output      logic                       rstbypen,
    output      pll_map_pkg::ratio_t        main_ratio,
    output      pll_map_pkg::ratio_t        zdiv0_ratio,
    output      pll_map_pkg::ratio_t        zdiv1_ratio,
    output      logic [`PLL_VCODIV_W-1:0]   vcodiv_ratio,
    output      logic                       pll_locked
);

    import pll_map_pkg::*;

    pll_state_e                 state;
    pll_state_e                 next_state;

    // update staged on entry into WRITE
    ratio_t                     pend_ratio;
    ratio_sel_e                 pend_sel;
    logic [`PLL_VCODIV_W-1:0]   pend_vcodiv;

    // state register
    // IDLE out of reset, so bring-up starts on the first edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        if (!pll_enable) begin
            // disable wins from any state
            next_state = NOP;
        end else begin
            case (state)
                NOP:     next_state = IDLE;
                IDLE:    next_state = SET;
                // hold reset bypass until the settle time is up
                SET: begin
                    if (lock_done) begin
                        next_state = STABLE;
                    end
                end
                STABLE: begin
                    if (apply) begin
                        next_state = WRITE;
                    end
                end
                // stay on a further apply, one update per cycle
                WRITE:   next_state = apply ? WRITE : STABLE;
                default: next_state = NOP;
            endcase
        end
    end

    // lock timer runs only during SET
    assign lock_count_en = (state == SET);

    // sequencing outputs, registered from next state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pllen      <= 1'b1;
            rstbypen   <= 1'b0;
            pll_locked <= 1'b0;
        end else begin
            pllen      <= (next_state != NOP);
            rstbypen   <= (next_state == SET);
            pll_locked <= (next_state == STABLE) || (next_state == WRITE);
        end
    end

    // stage the fields of an accepted update
    // a write seen outside STABLE/WRITE never reaches here
    always_ff @(posedge clk) begin
        if (next_state == WRITE) begin
            pend_ratio  <= new_ratio;
            pend_sel    <= new_sel;
            pend_vcodiv <= new_vcodiv;
        end
    end

    // divider outputs
    // the load happens in WRITE, one edge after staging
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_ratio   <= `PLL_RST_RATIO;
            zdiv0_ratio  <= `PLL_RST_ZDIV0;
            zdiv1_ratio  <= `PLL_RST_ZDIV1;
            vcodiv_ratio <= `PLL_RST_VCODIV;
        end else if (state == WRITE) begin
            // post-divider follows every update
            vcodiv_ratio <= pend_vcodiv;
            case (pend_sel)
                MAIN:    main_ratio  <= pend_ratio;
                ZDIV0:   zdiv0_ratio <= pend_ratio;
                ZDIV1:   zdiv1_ratio <= pend_ratio;
                // NONE, ratios keep their values
                default: ;
            endcase
        end
    end

endmodule : pll_map_core

`default_nettype wire

// ==== logic/pll_map_macros.svh ====
`ifndef PLL_MAP_MACROS_SVH
`define PLL_MAP_MACROS_SVH

// divider ratio field width
`define PLL_RATIO_W        10
// vco post-divider field width
`define PLL_VCODIV_W       2

// host register port
`define PLL_ADDR_W         2
`define PLL_DATA_W         16
`define PLL_ADDR_CTRL      2'd0
`define PLL_ADDR_RATIO     2'd1

// field positions inside the RATIO register
`define PLL_SEL_LSB        10
`define PLL_VCODIV_LSB     12

// lock settle time in clk cycles
`define PLL_LOCK_CYCLES    8

// power-on divider values
`define PLL_RST_RATIO      10'h0BC
`define PLL_RST_ZDIV0      10'h0C7
`define PLL_RST_ZDIV1      10'h019
`define PLL_RST_VCODIV     2'd0

`endif

// ==== logic/pll_map_pkg.sv ====
`default_nettype none

package pll_map_pkg;

    `include "pll_map_macros.svh"

    // sequencer states
    // SET takes encoding zero and the others count up from NOP
    typedef enum logic [3:0] {
        // reset bypass held during the lock wait
        SET    = 4'd0,
        // pll held off with pllen low
        NOP    = 4'd1,
        // enabled and one cycle ahead of the reset bypass
        IDLE   = 4'd2,
        // locked with steady ratios
        STABLE = 4'd3,
        // one ratio update per cycle here
        WRITE  = 4'd4
    } pll_state_e;

    // target of a ratio update
    typedef enum logic [1:0] {
        // only the vco post-divider changes
        NONE  = 2'd0,
        // main feedback divider
        MAIN  = 2'd1,
        // first output z-divider
        ZDIV0 = 2'd2,
        // second output z-divider
        ZDIV1 = 2'd3
    } ratio_sel_e;

    // divider ratio value used by the main and z-dividers
    typedef logic [`PLL_RATIO_W-1:0] ratio_t;

endpackage : pll_map_pkg

`default_nettype wire

// ==== logic/pll_map_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_map_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // host register port
    input  wire logic                       host_wr,
    input  wire logic [`PLL_ADDR_W-1:0]     host_addr,
    input  wire logic [`PLL_DATA_W-1:0]     host_wdata,
    // pll macro controls
    output      logic                       pllen,
    output      logic                       rstbypen,
    output      pll_map_pkg::ratio_t        main_ratio,
    output      pll_map_pkg::ratio_t        zdiv0_ratio,
    output      pll_map_pkg::ratio_t        zdiv1_ratio,
    output      logic [`PLL_VCODIV_W-1:0]   vcodiv_ratio,
    output      logic                       pll_locked
);

    import pll_map_pkg::*;

    // register block to sequencer
    logic                       pll_enable;
    logic                       apply;
    ratio_t                     new_ratio;
    ratio_sel_e                 new_sel;
    logic [`PLL_VCODIV_W-1:0]   new_vcodiv;

    // sequencer and lock timer
    logic                       lock_count_en;
    logic                       lock_done;

    pll_cfg_regs u_cfg_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .pll_enable (pll_enable),
        .apply      (apply),
        .new_ratio  (new_ratio),
        .new_sel    (new_sel),
        .new_vcodiv (new_vcodiv)
    );

    // settle time models the analog lock
    pll_lock_timer #(
        .LOCK_CYCLES (`PLL_LOCK_CYCLES)
    ) u_lock_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .lock_count_en (lock_count_en),
        .lock_done     (lock_done)
    );

    pll_map_core u_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .pll_enable    (pll_enable),
        .apply         (apply),
        .new_ratio     (new_ratio),
        .new_sel       (new_sel),
        .new_vcodiv    (new_vcodiv),
        .lock_done     (lock_done),
        .lock_count_en (lock_count_en),
        .pllen         (pllen),
        .rstbypen      (rstbypen),
        .main_ratio    (main_ratio),
        .zdiv0_ratio   (zdiv0_ratio),
        .zdiv1_ratio   (zdiv1_ratio),
        .vcodiv_ratio  (vcodiv_ratio),
        .pll_locked    (pll_locked)
    );

endmodule : pll_map_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the pll map testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module pll_map_tb --Mdir obj_dir -o pll_map_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pll_map_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== tb.f ====
+incdir+logic
logic/pll_map_pkg.sv
logic/pll_cfg_regs.sv
logic/pll_lock_timer.sv
logic/pll_map_core.sv
logic/pll_map_top.sv
verification/pll_map_props.sv
verification/pll_map_tb.sv

// ==== verification/pll_map_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_map_props (
    input wire logic                        clk,
    input wire logic                        rst_n,
    input wire logic                        pllen,
    input wire logic                        rstbypen,
    input wire logic                        pll_locked,
    input wire pll_map_pkg::ratio_t         main_ratio,
    input wire pll_map_pkg::ratio_t         zdiv0_ratio,
    input wire pll_map_pkg::ratio_t         zdiv1_ratio,
    input wire logic [`PLL_VCODIV_W-1:0]    vcodiv_ratio
);

    // count of failed properties for the testbench summary
    int unsigned fail_count = 0;

    // still no lock on the cycle after the pll was off
    a_lock_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        !pllen |=> !pll_locked)
        else begin
            fail_count++;
            $error("pll_locked high right after pllen was low");
        end

    // reset bypass ends only into lock or into a disable
    a_bypass_ends_in_lock: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rstbypen) |-> pll_locked || !pllen)
        else begin
            fail_count++;
            $error("rstbypen dropped without lock or disable");
        end

    // lock comes straight after a full SET stretch of LOCK_CYCLES+1 cycles
    a_lock_after_set: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pll_locked) |-> $past(rstbypen, 1) && $past(rstbypen, `PLL_LOCK_CYCLES + 1)
            && !$past(rstbypen, `PLL_LOCK_CYCLES + 2))
        else begin
            fail_count++;
            $error("pll_locked rose without the full reset bypass stretch");
        end

    // dividers frozen while unlocked
    a_ratios_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !pll_locked |=> $stable(main_ratio) && $stable(zdiv0_ratio)
            && $stable(zdiv1_ratio) && $stable(vcodiv_ratio))
        else begin
            fail_count++;
            $error("a divider output changed while unlocked");
        end

endmodule : pll_map_props

bind pll_map_top pll_map_props u_props (.*);

`default_nettype wire

// ==== verification/pll_map_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pll_map_macros.svh"

module pll_map_tb;

    import pll_map_pkg::*;

    // six short tests, about 200 cycles each at most
    localparam int unsigned MAX_CYCLES = 2000;
    // model step at which the pll counts as locked
    localparam int unsigned LOCK_SEQ = `PLL_LOCK_CYCLES + 3;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       host_wr;
    logic [`PLL_ADDR_W-1:0]     host_addr;
    logic [`PLL_DATA_W-1:0]     host_wdata;
    logic                       pllen;
    logic                       rstbypen;
    logic                       pll_locked;
    ratio_t                     main_ratio, zdiv0_ratio, zdiv1_ratio;
    logic [`PLL_VCODIV_W-1:0]   vcodiv_ratio;

    // model step: 0 off, 1 idle, 2 up to LOCK_SEQ-1 reset bypass, then locked
    int unsigned                seq;
    logic                       exp_en;
    ratio_t                     exp_main, exp_zdiv0, exp_zdiv1;
    logic [`PLL_VCODIV_W-1:0]   exp_vcodiv;
    // accepted RATIO words, two edges away from the outputs
    logic [1:0]                 stage_valid;
    logic [`PLL_DATA_W-1:0]     stage_data [2];

    int unsigned                cycles = 0;
    int unsigned                value_errors = 0;
    int unsigned                other_errors = 0;

    pll_map_top dut (.*);

    always #2 clk = ~clk;

    // reference model, moves on the same edges as the DUT
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq         = 1;
            exp_en      = 1'b1;
            exp_main    = `PLL_RST_RATIO;
            exp_zdiv0   = `PLL_RST_ZDIV0;
            exp_zdiv1   = `PLL_RST_ZDIV1;
            exp_vcodiv  = `PLL_RST_VCODIV;
            stage_valid = 2'b00;
        end else begin
            // word taken two edges back lands now
            if (stage_valid[1]) begin
                exp_vcodiv = stage_data[1][13:12];
                case (stage_data[1][11:10])
                    2'd1:    exp_main  = stage_data[1][9:0];
                    2'd2:    exp_zdiv0 = stage_data[1][9:0];
                    2'd3:    exp_zdiv1 = stage_data[1][9:0];
                    default: ;
                endcase
            end
            stage_valid[1] = stage_valid[0];
            stage_data[1]  = stage_data[0];
            // enable level from before the edge drives the bring-up
            if (!exp_en) begin
                seq = 0;
            end else if (seq < LOCK_SEQ) begin
                seq = seq + 1;
            end
            if (host_wr && host_addr == `PLL_ADDR_CTRL) begin
                exp_en = host_wdata[0];
            end
            // needs lock and enable right after this edge
            stage_valid[0] = host_wr && host_addr == `PLL_ADDR_RATIO
                             && seq >= LOCK_SEQ && exp_en;
            stage_data[0]  = host_wdata;
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // outputs against the model on every falling edge, reset included
    always @(negedge clk) begin
        check_value("pllen", 16'(pllen), 16'(seq != 0));
        check_value("rstbypen", 16'(rstbypen), 16'(seq >= 2 && seq < LOCK_SEQ));
        check_value("pll_locked", 16'(pll_locked), 16'(seq >= LOCK_SEQ));
        check_value("main_ratio", 16'(main_ratio), 16'(exp_main));
        check_value("zdiv0_ratio", 16'(zdiv0_ratio), 16'(exp_zdiv0));
        check_value("zdiv1_ratio", 16'(zdiv1_ratio), 16'(exp_zdiv1));
        check_value("vcodiv_ratio", 16'(vcodiv_ratio), 16'(exp_vcodiv));
    end

    task automatic report_counts();
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, dut.u_props.fail_count);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run still going after %0d cycles", MAX_CYCLES);
            report_counts();
            $display("Some tests failed");
            $finish;
        end
    end

    // one-cycle strobe, back on the next falling edge with the strobe low
    task automatic drive_write(input logic [`PLL_ADDR_W-1:0] addr,
                               input logic [`PLL_DATA_W-1:0] data);
        host_wr    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_wr    = 1'b0;
    endtask

    // random ratio and vco fields, selector given
    task automatic write_ratio(input logic [1:0] sel);
        logic [`PLL_DATA_W-1:0] word;
        word        = `PLL_DATA_W'($urandom);
        word[11:10] = sel;
        drive_write(`PLL_ADDR_RATIO, word);
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    // falling edges until pll_locked, bounded
    task automatic wait_for_lock(input int unsigned expected);
        int unsigned n;
        n = 0;
        while (!pll_locked && n < 4 * LOCK_SEQ) begin
            @(negedge clk);
            n++;
        end
        assert (pll_locked && n == expected) else begin
            other_errors++;
            $display("lock wait was %0d cycles where %0d were expected", n, expected);
        end
    endtask

    initial begin
        void'($urandom(27));
        host_wr    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rst_n      = 1'b1;
        #1 rst_n = 1'b0;
        repeat (2) @(negedge clk);
        // bring-up from reset
        rst_n = 1'b1;
        wait_for_lock(`PLL_LOCK_CYCLES + 2);
        idle_cycles(2);
        // isolated writes, every selector three times
        for (int i = 0; i < 12; i++) begin
            write_ratio(2'(i));
            idle_cycles(3);
        end
        // burst, one write per cycle
        repeat (8) write_ratio(2'($urandom));
        idle_cycles(4);
        // unused addresses
        drive_write(2'd2, `PLL_DATA_W'($urandom));
        drive_write(2'd3, `PLL_DATA_W'($urandom));
        idle_cycles(3);
        // disable, then writes that must be dropped
        drive_write(`PLL_ADDR_CTRL, 16'h0000);
        idle_cycles(2);
        repeat (4) write_ratio(2'($urandom));
        idle_cycles(3);
        // re-enable, NOP adds one edge, writes land in the lock wait
        drive_write(`PLL_ADDR_CTRL, 16'h0001);
        repeat (4) write_ratio(2'($urandom));
        wait_for_lock(`PLL_LOCK_CYCLES + 3 - 4);
        idle_cycles(2);
        for (int i = 0; i < 4; i++) begin
            write_ratio(2'(i));
            idle_cycles(3);
        end
        idle_cycles(4);
        report_counts();
        if (value_errors + other_errors + dut.u_props.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : pll_map_tb

`default_nettype wire
